/* verilog/cpu_settings.svh */
//==========================================================================
// CPU settings
// word and register widths, memory depths and the instruction encodings
// of the MIPS32 subset run by the pipeline
//==========================================================================
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_DATA_W      32
`define CPU_REG_ADDR_W  5
`define CPU_IMEM_ADDR_W 9
`define CPU_DMEM_ADDR_W 10

`define CPU_OP_RTYPE    6'h00
`define CPU_OP_ADDI     6'h08
`define CPU_OP_LW       6'h23
`define CPU_OP_SW       6'h2b

// funct field, R format only
`define CPU_FN_ADD      6'h20
`define CPU_FN_SUB      6'h22
`define CPU_FN_AND      6'h24
`define CPU_FN_OR       6'h25
`define CPU_FN_SLT      6'h2a

`endif

/* verilog/cpu_pkg.sv */
//==========================================================================
// CPU package
// instruction word views and the ALU operation type
//==========================================================================
`include "cpu_settings.svh"

package cpu_pkg;

   typedef struct packed {
      logic [5:0]                 opcode;
      logic [`CPU_REG_ADDR_W-1:0] rs;
      logic [`CPU_REG_ADDR_W-1:0] rt;
      logic [`CPU_REG_ADDR_W-1:0] rd;
      logic [4:0]                 shamt;
      logic [5:0]                 funct;
   } r_fmt_t;

   typedef struct packed {
      logic [5:0]                 opcode;
      logic [`CPU_REG_ADDR_W-1:0] rs;
      logic [`CPU_REG_ADDR_W-1:0] rt;
      logic [15:0]                imm;
   } i_fmt_t;

   // one instruction word, read as R or I format
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_t;

   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_t;

endpackage

/* verilog/dual_port_ram.sv */
//==========================================================================
// Dual port RAM
// word memory with a pipeline port and an external port, both with a
// write and a registered read
//==========================================================================
`timescale 1ns/10ps
`include "cpu_settings.svh"

module dual_port_ram #(
   parameter int ADDR_W = 9
) (
   input  logic                   clk,
   input  logic [ADDR_W-1:0]      pipe_addr,
   input  logic                   pipe_wen,
   input  logic [`CPU_DATA_W-1:0] pipe_wdata,
   output logic [`CPU_DATA_W-1:0] pipe_rdata,
   input  logic [ADDR_W-1:0]      ext_addr,
   input  logic                   ext_wen,
   input  logic [`CPU_DATA_W-1:0] ext_wdata,
   output logic [`CPU_DATA_W-1:0] ext_rdata
);

   logic [`CPU_DATA_W-1:0] mem [2**ADDR_W];

   // external write comes last so it wins on an address clash
   always_ff @(posedge clk) begin
      if (pipe_wen) begin
         mem[pipe_addr] <= pipe_wdata;
      end
      if (ext_wen) begin
         mem[ext_addr] <= ext_wdata;
      end
      pipe_rdata <= mem[pipe_addr];
      ext_rdata  <= mem[ext_addr];
   end

endmodule

/* verilog/fetch_stage.sv */
//==========================================================================
// Fetch stage
// program counter and instruction memory, with a second port for
// loading and reading the program from outside
//==========================================================================
`timescale 1ns/10ps
`include "cpu_settings.svh"

module fetch_stage
   import cpu_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       run,
   input  logic                       hold,
   input  logic [`CPU_IMEM_ADDR_W-1:0] imem_addr,
   input  logic                       imem_wen,
   input  logic [`CPU_DATA_W-1:0]     imem_wdata,
   output logic [`CPU_DATA_W-1:0]     imem_rdata,
   output instr_t                     instr,
   output logic                       instr_valid
);

   logic [`CPU_DATA_W-1:0] pc;
   logic [`CPU_DATA_W-1:0] pc_next;
   logic [`CPU_DATA_W-1:0] rdata;

   // memory sees the next pc, so its registered word always belongs to pc
   // and stays frozen whenever pc holds
   always_comb begin
      if (rst) begin
         pc_next = '0;
      end else if (run && !hold) begin
         pc_next = pc + `CPU_DATA_W'd4;
      end else begin
         pc_next = pc;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc          <= '0;
         instr_valid <= 1'b0;
      end else begin
         pc          <= pc_next;
         instr_valid <= 1'b1;
      end
   end

   dual_port_ram #(
      .ADDR_W(`CPU_IMEM_ADDR_W)
   ) imem (
      .clk       (clk),
      .pipe_addr (pc_next[`CPU_IMEM_ADDR_W+1:2]),
      .pipe_wen  (1'b0),
      .pipe_wdata('0),
      .pipe_rdata(rdata),
      .ext_addr  (imem_addr),
      .ext_wen   (imem_wen),
      .ext_wdata (imem_wdata),
      .ext_rdata (imem_rdata)
   );

   assign instr = rdata;

endmodule

/* verilog/decode_stage.sv */
//==========================================================================
// Decode stage
// control decode, register file, load-use hazard detection and the
// decode-to-execute pipeline register
//==========================================================================
`timescale 1ns/10ps
`include "cpu_settings.svh"

module decode_stage
   import cpu_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       run,
   input  instr_t                     instr,
   input  logic                       instr_valid,
   input  logic                       wb_wen,
   input  logic [`CPU_REG_ADDR_W-1:0] wb_reg,
   input  logic [`CPU_DATA_W-1:0]     wb_data,
   input  logic                       ex_is_load,
   input  logic [`CPU_REG_ADDR_W-1:0] ex_rt,
   output logic                       hold,
   output logic [`CPU_REG_ADDR_W-1:0] id_rs,
   output logic [`CPU_REG_ADDR_W-1:0] id_rt,
   output logic [`CPU_REG_ADDR_W-1:0] id_rd_sel,
   output logic [`CPU_DATA_W-1:0]     id_a,
   output logic [`CPU_DATA_W-1:0]     id_b,
   output logic [`CPU_DATA_W-1:0]     id_imm,
   output alu_op_t                    id_alu_op,
   output logic                       id_alu_src,
   output logic                       id_reg_wen,
   output logic                       id_mem_wen,
   output logic                       id_is_load
);

   logic [`CPU_DATA_W-1:0]     regs [32];
   logic                       reg_write;
   logic [`CPU_DATA_W-1:0]     rd_a;
   logic [`CPU_DATA_W-1:0]     rd_b;
   logic [`CPU_REG_ADDR_W-1:0] dest;
   alu_op_t                    alu_op;
   logic                       alu_src;
   logic                       reg_wen;
   logic                       mem_wen;
   logic                       is_load;
   logic                       bubble;

   // anything outside the subset keeps every enable low
   always_comb begin
      dest    = instr.i.rt;
      alu_op  = ALU_ADD;
      alu_src = 1'b0;
      reg_wen = 1'b0;
      mem_wen = 1'b0;
      is_load = 1'b0;
      case (instr.r.opcode)
         `CPU_OP_RTYPE: begin
            dest    = instr.r.rd;
            reg_wen = 1'b1;
            case (instr.r.funct)
               `CPU_FN_ADD: alu_op = ALU_ADD;
               `CPU_FN_SUB: alu_op = ALU_SUB;
               `CPU_FN_AND: alu_op = ALU_AND;
               `CPU_FN_OR:  alu_op = ALU_OR;
               `CPU_FN_SLT: alu_op = ALU_SLT;
               default:     reg_wen = 1'b0;
            endcase
         end
         `CPU_OP_ADDI: begin
            alu_src = 1'b1;
            reg_wen = 1'b1;
         end
         `CPU_OP_LW: begin
            alu_src = 1'b1;
            reg_wen = 1'b1;
            is_load = 1'b1;
         end
         `CPU_OP_SW: begin
            alu_src = 1'b1;
            mem_wen = 1'b1;
         end
         default: ;
      endcase
   end

   // load in execute feeding this instruction
   assign hold   = ex_is_load && (ex_rt == instr.r.rs || ex_rt == instr.r.rt);
   assign bubble = hold || !instr_valid;

   assign reg_write = run && wb_wen && (wb_reg != '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (reg_write) begin
         regs[wb_reg] <= wb_data;
      end
   end

   // write-first read, r0 is hardwired to zero
   always_comb begin
      rd_a = regs[instr.r.rs];
      rd_b = regs[instr.r.rt];
      if (reg_write && wb_reg == instr.r.rs) begin
         rd_a = wb_data;
      end
      if (reg_write && wb_reg == instr.r.rt) begin
         rd_b = wb_data;
      end
      if (instr.r.rs == '0) begin
         rd_a = '0;
      end
      if (instr.r.rt == '0) begin
         rd_b = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         id_reg_wen <= 1'b0;
         id_mem_wen <= 1'b0;
         id_is_load <= 1'b0;
      end else if (run) begin
         id_reg_wen <= reg_wen && !bubble && (dest != '0);
         id_mem_wen <= mem_wen && !bubble;
         id_is_load <= is_load && !bubble;
      end
   end

   always_ff @(posedge clk) begin
      if (run) begin
         id_rs      <= instr.r.rs;
         id_rt      <= instr.r.rt;
         id_rd_sel  <= dest;
         id_a       <= rd_a;
         id_b       <= rd_b;
         id_imm     <= {{(`CPU_DATA_W-16){instr.i.imm[15]}}, instr.i.imm};
         id_alu_op  <= alu_op;
         id_alu_src <= alu_src;
      end
   end

endmodule

/* verilog/execute_stage.sv */
//==========================================================================
// Execute stage
// operand forwarding, immediate select, ALU and the execute-to-memory
// pipeline register
//==========================================================================
`timescale 1ns/10ps
`include "cpu_settings.svh"

module execute_stage
   import cpu_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       run,
   input  logic [`CPU_REG_ADDR_W-1:0] id_rs,
   input  logic [`CPU_REG_ADDR_W-1:0] id_rt,
   input  logic [`CPU_REG_ADDR_W-1:0] id_rd_sel,
   input  logic [`CPU_DATA_W-1:0]     id_a,
   input  logic [`CPU_DATA_W-1:0]     id_b,
   input  logic [`CPU_DATA_W-1:0]     id_imm,
   input  alu_op_t                    id_alu_op,
   input  logic                       id_alu_src,
   input  logic                       id_reg_wen,
   input  logic                       id_mem_wen,
   input  logic                       id_is_load,
   input  logic                       wb_wen,
   input  logic [`CPU_REG_ADDR_W-1:0] wb_reg,
   input  logic [`CPU_DATA_W-1:0]     wb_data,
   output logic [`CPU_DATA_W-1:0]     ex_alu_out,
   output logic [`CPU_DATA_W-1:0]     ex_store_data,
   output logic [`CPU_REG_ADDR_W-1:0] ex_dest,
   output logic                       ex_reg_wen,
   output logic                       ex_mem_wen,
   output logic                       ex_is_load
);

   logic [`CPU_DATA_W-1:0] op_a;
   logic [`CPU_DATA_W-1:0] fwd_b;
   logic [`CPU_DATA_W-1:0] op_b;
   logic [`CPU_DATA_W-1:0] alu_res;

   // memory stage result is the newest, then writeback, then the regfile read
   always_comb begin
      op_a  = id_a;
      fwd_b = id_b;
      if (ex_reg_wen && ex_dest == id_rs) begin
         op_a = ex_alu_out;
      end else if (wb_wen && wb_reg == id_rs) begin
         op_a = wb_data;
      end
      if (ex_reg_wen && ex_dest == id_rt) begin
         fwd_b = ex_alu_out;
      end else if (wb_wen && wb_reg == id_rt) begin
         fwd_b = wb_data;
      end
      op_b = id_alu_src ? id_imm : fwd_b;
   end

   always_comb begin
      case (id_alu_op)
         ALU_SUB: alu_res = op_a - op_b;
         ALU_AND: alu_res = op_a & op_b;
         ALU_OR:  alu_res = op_a | op_b;
         ALU_SLT: alu_res = {{(`CPU_DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         default: alu_res = op_a + op_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ex_reg_wen <= 1'b0;
         ex_mem_wen <= 1'b0;
         ex_is_load <= 1'b0;
      end else if (run) begin
         ex_reg_wen <= id_reg_wen;
         ex_mem_wen <= id_mem_wen;
         ex_is_load <= id_is_load;
      end
   end

   always_ff @(posedge clk) begin
      if (run) begin
         ex_alu_out    <= alu_res;
         ex_store_data <= fwd_b;
         ex_dest       <= id_rd_sel;
      end
   end

endmodule

/* verilog/memory_stage.sv */
//==========================================================================
// Memory stage
// data memory access, the memory-to-writeback register and the
// writeback data select
//==========================================================================
`timescale 1ns/10ps
`include "cpu_settings.svh"

module memory_stage (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        run,
   input  logic [`CPU_DATA_W-1:0]      ex_alu_out,
   input  logic [`CPU_DATA_W-1:0]      ex_store_data,
   input  logic [`CPU_REG_ADDR_W-1:0]  ex_dest,
   input  logic                        ex_reg_wen,
   input  logic                        ex_mem_wen,
   input  logic                        ex_is_load,
   input  logic [`CPU_DMEM_ADDR_W-1:0] dmem_addr,
   input  logic                        dmem_wen,
   input  logic [`CPU_DATA_W-1:0]      dmem_wdata,
   output logic [`CPU_DATA_W-1:0]      dmem_rdata,
   output logic                        wb_wen,
   output logic [`CPU_REG_ADDR_W-1:0]  wb_reg,
   output logic [`CPU_DATA_W-1:0]      wb_data
);

   logic [`CPU_DATA_W-1:0]      wb_alu;
   logic                        wb_is_load;
   logic [`CPU_DATA_W-1:0]      load_data;
   logic [`CPU_DMEM_ADDR_W-1:0] pipe_addr;

   // while frozen, keep rereading the writeback address so the load data holds
   assign pipe_addr = run ? ex_alu_out[`CPU_DMEM_ADDR_W+1:2] : wb_alu[`CPU_DMEM_ADDR_W+1:2];

   dual_port_ram #(
      .ADDR_W(`CPU_DMEM_ADDR_W)
   ) dmem (
      .clk       (clk),
      .pipe_addr (pipe_addr),
      .pipe_wen  (run && ex_mem_wen),
      .pipe_wdata(ex_store_data),
      .pipe_rdata(load_data),
      .ext_addr  (dmem_addr),
      .ext_wen   (dmem_wen),
      .ext_wdata (dmem_wdata),
      .ext_rdata (dmem_rdata)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_wen     <= 1'b0;
         wb_is_load <= 1'b0;
      end else if (run) begin
         wb_wen     <= ex_reg_wen;
         wb_is_load <= ex_is_load;
      end
   end

   always_ff @(posedge clk) begin
      if (run) begin
         wb_reg <= ex_dest;
         wb_alu <= ex_alu_out;
      end
   end

   assign wb_data = wb_is_load ? load_data : wb_alu;

endmodule

/* verilog/cpu.sv */
//==========================================================================
// CPU top
// five-stage pipelined MIPS32 subset core with external access to the
// instruction and data memories
//==========================================================================
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpu
   import cpu_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        run,
   input  logic [`CPU_IMEM_ADDR_W-1:0] imem_addr,
   input  logic                        imem_wen,
   input  logic [`CPU_DATA_W-1:0]      imem_wdata,
   output logic [`CPU_DATA_W-1:0]      imem_rdata,
   input  logic [`CPU_DMEM_ADDR_W-1:0] dmem_addr,
   input  logic                        dmem_wen,
   input  logic [`CPU_DATA_W-1:0]      dmem_wdata,
   output logic [`CPU_DATA_W-1:0]      dmem_rdata
);

   instr_t                     instr;
   logic                       instr_valid;
   logic                       hold;
   logic [`CPU_REG_ADDR_W-1:0] id_rs;
   logic [`CPU_REG_ADDR_W-1:0] id_rt;
   logic [`CPU_REG_ADDR_W-1:0] id_rd_sel;
   logic [`CPU_DATA_W-1:0]     id_a;
   logic [`CPU_DATA_W-1:0]     id_b;
   logic [`CPU_DATA_W-1:0]     id_imm;
   alu_op_t                    id_alu_op;
   logic                       id_alu_src;
   logic                       id_reg_wen;
   logic                       id_mem_wen;
   logic                       id_is_load;
   logic [`CPU_DATA_W-1:0]     ex_alu_out;
   logic [`CPU_DATA_W-1:0]     ex_store_data;
   logic [`CPU_REG_ADDR_W-1:0] ex_dest;
   logic                       ex_reg_wen;
   logic                       ex_mem_wen;
   logic                       ex_is_load;
   logic                       wb_wen;
   logic [`CPU_REG_ADDR_W-1:0] wb_reg;
   logic [`CPU_DATA_W-1:0]     wb_data;

   fetch_stage u_fetch (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .hold       (hold),
      .imem_addr  (imem_addr),
      .imem_wen   (imem_wen),
      .imem_wdata (imem_wdata),
      .imem_rdata (imem_rdata),
      .instr      (instr),
      .instr_valid(instr_valid)
   );

   // hazard check looks at the instruction now sitting in execute
   decode_stage u_decode (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .instr      (instr),
      .instr_valid(instr_valid),
      .wb_wen     (wb_wen),
      .wb_reg     (wb_reg),
      .wb_data    (wb_data),
      .ex_is_load (id_is_load),
      .ex_rt      (id_rt),
      .hold       (hold),
      .id_rs      (id_rs),
      .id_rt      (id_rt),
      .id_rd_sel  (id_rd_sel),
      .id_a       (id_a),
      .id_b       (id_b),
      .id_imm     (id_imm),
      .id_alu_op  (id_alu_op),
      .id_alu_src (id_alu_src),
      .id_reg_wen (id_reg_wen),
      .id_mem_wen (id_mem_wen),
      .id_is_load (id_is_load)
   );

   execute_stage u_execute (
      .clk          (clk),
      .rst          (rst),
      .run          (run),
      .id_rs        (id_rs),
      .id_rt        (id_rt),
      .id_rd_sel    (id_rd_sel),
      .id_a         (id_a),
      .id_b         (id_b),
      .id_imm       (id_imm),
      .id_alu_op    (id_alu_op),
      .id_alu_src   (id_alu_src),
      .id_reg_wen   (id_reg_wen),
      .id_mem_wen   (id_mem_wen),
      .id_is_load   (id_is_load),
      .wb_wen       (wb_wen),
      .wb_reg       (wb_reg),
      .wb_data      (wb_data),
      .ex_alu_out   (ex_alu_out),
      .ex_store_data(ex_store_data),
      .ex_dest      (ex_dest),
      .ex_reg_wen   (ex_reg_wen),
      .ex_mem_wen   (ex_mem_wen),
      .ex_is_load   (ex_is_load)
   );

   memory_stage u_memory (
      .clk          (clk),
      .rst          (rst),
      .run          (run),
      .ex_alu_out   (ex_alu_out),
      .ex_store_data(ex_store_data),
      .ex_dest      (ex_dest),
      .ex_reg_wen   (ex_reg_wen),
      .ex_mem_wen   (ex_mem_wen),
      .ex_is_load   (ex_is_load),
      .dmem_addr    (dmem_addr),
      .dmem_wen     (dmem_wen),
      .dmem_wdata   (dmem_wdata),
      .dmem_rdata   (dmem_rdata),
      .wb_wen       (wb_wen),
      .wb_reg       (wb_reg),
      .wb_data      (wb_data)
   );

endmodule

/* sim/cpu_chk.sv */
//==========================================================================
// CPU checker
// concurrent assertions on hold, writes after reset and writes while the
// pipeline is frozen, bound into the decode and memory stages
//==========================================================================
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpu_chk (
   input logic                   clk,
   input logic                   rst,
   input logic                   run,
   input logic                   hold,
   input logic                   reg_wen,
   input logic                   mem_wen,
   input logic                   pend_wen,
   input logic [`CPU_DATA_W-1:0] pend_word
);

   // a stall is a single bubble per load-use pair
   a_hold_once: assert property (@(posedge clk) disable iff (rst)
      (run && hold) |=> !(run && hold))
      else $error("hold stayed high for two running cycles");

   a_quiet_after_reset: assert property (@(posedge clk)
      (!rst && $past(rst)) |-> (!reg_wen && !mem_wen))
      else $error("write in the first cycle after reset");

   // a write held back by a low run leaves its target word untouched
   a_write_frozen: assert property (@(posedge clk) disable iff (rst)
      (!run && pend_wen) |=> $stable(pend_word))
      else $error("pipeline write while run is low");

endmodule

bind decode_stage cpu_chk u_decode_chk (
   .clk      (clk),
   .rst      (rst),
   .run      (run),
   .hold     (hold),
   .reg_wen  (reg_write),
   .mem_wen  (1'b0),
   .pend_wen (wb_wen),
   .pend_word(regs[wb_reg])
);

bind memory_stage cpu_chk u_memory_chk (
   .clk      (clk),
   .rst      (rst),
   .run      (run),
   .hold     (1'b0),
   .reg_wen  (1'b0),
   .mem_wen  (run && ex_mem_wen),
   .pend_wen (ex_mem_wen && !(dmem_wen && dmem_addr == wb_alu[`CPU_DMEM_ADDR_W+1:2])),
   .pend_word(dmem.mem[wb_alu[`CPU_DMEM_ADDR_W+1:2]])
);

/* sim/cpu_tb.sv */
//==========================================================================
// CPU testbench
// directed tests of the pipelined core, with a reference model that runs
// each program in order and predicts the words left in data memory
//==========================================================================
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpu_tb
   import cpu_pkg::*;
();

   localparam int CLK_NS      = 8;
   localparam int REGION      = 64;
   localparam int RUN_MARGIN  = 16;
   localparam int EXT_CYCLES  = 100;
   localparam int PROG_CYCLES = 800;
   localparam int WATCHDOG_NS = 2 * (EXT_CYCLES + 4 * PROG_CYCLES) * CLK_NS;

   logic                        clk;
   logic                        rst;
   logic                        run;
   logic [`CPU_IMEM_ADDR_W-1:0] imem_addr;
   logic                        imem_wen;
   logic [`CPU_DATA_W-1:0]      imem_wdata;
   logic [`CPU_DATA_W-1:0]      imem_rdata;
   logic [`CPU_DMEM_ADDR_W-1:0] dmem_addr;
   logic                        dmem_wen;
   logic [`CPU_DATA_W-1:0]      dmem_wdata;
   logic [`CPU_DATA_W-1:0]      dmem_rdata;

   logic [31:0]            lfsr = 32'ha43ebe0e;
   instr_t                 prog [$];
   instr_t                 alu_prog [$];
   logic [`CPU_DATA_W-1:0] mregs [32];
   logic [`CPU_DATA_W-1:0] mmem [2**`CPU_DMEM_ADDR_W];

   cpu DUT (.*);

   always #(CLK_NS / 2) clk = ~clk;

   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v = {v[30:0], lfsr_bit()};
      end
      return v;
   endfunction

   function automatic instr_t r_op(input logic [5:0] funct, input int rd, rs, rt);
      instr_t w;
      w.r.opcode = `CPU_OP_RTYPE;
      w.r.rs     = rs;
      w.r.rt     = rt;
      w.r.rd     = rd;
      w.r.shamt  = '0;
      w.r.funct  = funct;
      return w;
   endfunction

   function automatic instr_t i_op(input logic [5:0] op, input int rt, rs,
                                   input logic [15:0] imm);
      instr_t w;
      w.i.opcode = op;
      w.i.rs     = rs;
      w.i.rt     = rt;
      w.i.imm    = imm;
      return w;
   endfunction

   task automatic report_failure(input string msg);
      $display("CHECK FAILED at %0d ns: %s", $time, msg);
      $display("sim failed");
      $fatal(1, "stopping at the first error");
   endtask

   // every task starts and ends 1 ns after a rising edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic reset_dut();
      run = 1'b0;
      rst = 1'b1;
      repeat (4) next_cycle();
      rst = 1'b0;
   endtask

   task automatic write_imem(input int a, input logic [31:0] d);
      imem_addr  = a;
      imem_wdata = d;
      imem_wen   = 1'b1;
      next_cycle();
      imem_wen   = 1'b0;
   endtask

   task automatic read_imem(input int a, output logic [31:0] d);
      imem_addr = a;
      next_cycle();
      d = imem_rdata;
   endtask

   task automatic write_dmem(input int a, input logic [31:0] d);
      dmem_addr  = a;
      dmem_wdata = d;
      dmem_wen   = 1'b1;
      next_cycle();
      dmem_wen   = 1'b0;
   endtask

   task automatic read_dmem(input int a, output logic [31:0] d);
      dmem_addr = a;
      next_cycle();
      d = dmem_rdata;
   endtask

   task automatic preload(input int a, input logic [31:0] d);
      write_dmem(a, d);
      mmem[a] = d;
   endtask

   task automatic clear_results();
      for (int a = 0; a < REGION; a++) begin
         preload(a, '0);
      end
   endtask

   task automatic model_write(input int idx, input logic [31:0] v);
      if (idx != 0) begin
         mregs[idx] = v;
      end
   endtask

   // in-order execution, anything outside the subset does nothing
   task automatic model_run();
      instr_t      w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] ea;
      for (int r = 0; r < 32; r++) begin
         mregs[r] = '0;
      end
      foreach (prog[k]) begin
         w  = prog[k];
         a  = mregs[w.i.rs];
         b  = mregs[w.i.rt];
         ea = a + {{16{w.i.imm[15]}}, w.i.imm};
         case (w.r.opcode)
            `CPU_OP_RTYPE: begin
               case (w.r.funct)
                  `CPU_FN_ADD: model_write(w.r.rd, a + b);
                  `CPU_FN_SUB: model_write(w.r.rd, a - b);
                  `CPU_FN_AND: model_write(w.r.rd, a & b);
                  `CPU_FN_OR:  model_write(w.r.rd, a | b);
                  `CPU_FN_SLT: model_write(w.r.rd, ($signed(a) < $signed(b)) ? 1 : 0);
                  default: ;
               endcase
            end
            `CPU_OP_ADDI: model_write(w.i.rt, ea);
            `CPU_OP_LW:   model_write(w.i.rt, mmem[ea[`CPU_DMEM_ADDR_W+1:2]]);
            `CPU_OP_SW:   mmem[ea[`CPU_DMEM_ADDR_W+1:2]] = b;
            default: ;
         endcase
      end
   endtask

   // the rest of instruction memory is filled with nops
   task automatic load_program();
      for (int a = 0; a < 2**`CPU_IMEM_ADDR_W; a++) begin
         write_imem(a, (a < prog.size()) ? prog[a] : '0);
      end
   endtask

   task automatic run_cycles(input int n);
      run = 1'b1;
      repeat (n) next_cycle();
      run = 1'b0;
   endtask

   task automatic run_with_freezes(input int n);
      int high;
      high = 0;
      while (high < n) begin
         run = lfsr_bit();
         if (run) begin
            high++;
         end
         next_cycle();
      end
      run = 1'b0;
   endtask

   task automatic check_results(input string name);
      logic [31:0] got;
      for (int a = 0; a < REGION; a++) begin
         read_dmem(a, got);
         assert (got === mmem[a])
            else report_failure($sformatf("%s dmem[%0d] is %h, expected %h",
                                          name, a, got, mmem[a]));
      end
   endtask

   task automatic run_program(input string name, input bit freeze);
      load_program();
      model_run();
      if (freeze) begin
         run_with_freezes(prog.size() + RUN_MARGIN);
      end else begin
         run_cycles(prog.size() + RUN_MARGIN);
      end
      check_results(name);
   endtask

   task automatic test_external_access();
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] got;
      for (int k = 0; k < 8; k++) begin
         a = random_bits(`CPU_IMEM_ADDR_W);
         d = random_bits(32);
         write_imem(a, d);
         read_imem(a, got);
         assert (got === d)
            else report_failure($sformatf("imem[%0d] is %h, expected %h", a, got, d));
         a = random_bits(`CPU_DMEM_ADDR_W);
         d = random_bits(32);
         write_dmem(a, d);
         read_dmem(a, got);
         assert (got === d)
            else report_failure($sformatf("dmem[%0d] is %h, expected %h", a, got, d));
      end
   endtask

   // back-to-back dependencies exercise both forward paths
   task automatic test_alu_forwarding();
      reset_dut();
      clear_results();
      prog.delete();
      prog.push_back(i_op(`CPU_OP_ADDI, 1, 0, 16'd5));
      prog.push_back(i_op(`CPU_OP_ADDI, 2, 1, 16'hfff4));
      prog.push_back(r_op(`CPU_FN_ADD, 3, 1, 2));
      prog.push_back(r_op(`CPU_FN_SUB, 4, 3, 1));
      prog.push_back(r_op(`CPU_FN_AND, 5, 4, 1));
      prog.push_back(r_op(`CPU_FN_OR, 6, 5, 2));
      prog.push_back(r_op(`CPU_FN_SLT, 7, 2, 1));
      prog.push_back(r_op(`CPU_FN_SLT, 8, 1, 2));
      prog.push_back(r_op(`CPU_FN_SLT, 9, 4, 3));
      prog.push_back(i_op(`CPU_OP_ADDI, 10, 0, random_bits(16)));
      prog.push_back(i_op(`CPU_OP_ADDI, 11, 10, random_bits(16)));
      prog.push_back(r_op(`CPU_FN_SLT, 12, 11, 10));
      for (int r = 12; r > 0; r--) begin
         prog.push_back(i_op(`CPU_OP_SW, r, 0, 4 * r));
      end
      alu_prog = prog;
      run_program("alu", 1'b0);
   endtask

   task automatic test_load_use();
      reset_dut();
      clear_results();
      preload(40, random_bits(32));
      preload(41, random_bits(32));
      prog.delete();
      prog.push_back(i_op(`CPU_OP_LW, 1, 0, 16'd160));
      prog.push_back(r_op(`CPU_FN_ADD, 2, 1, 1));
      prog.push_back(i_op(`CPU_OP_SW, 2, 0, 16'd0));
      prog.push_back(i_op(`CPU_OP_LW, 3, 0, 16'd164));
      prog.push_back(i_op(`CPU_OP_SW, 3, 0, 16'd4));
      prog.push_back(i_op(`CPU_OP_LW, 4, 0, 16'd160));
      prog.push_back(i_op(`CPU_OP_ADDI, 5, 4, 16'd1));
      prog.push_back(i_op(`CPU_OP_SW, 5, 0, 16'd8));
      prog.push_back(i_op(`CPU_OP_LW, 6, 0, 16'd164));
      prog.push_back(r_op(`CPU_FN_SUB, 7, 6, 4));
      prog.push_back(i_op(`CPU_OP_SW, 7, 0, 16'd12));
      run_program("load-use", 1'b0);
   endtask

   task automatic test_freeze();
      reset_dut();
      clear_results();
      prog = alu_prog;
      run_program("freeze", 1'b1);
   endtask

   task automatic test_zero_and_nops();
      reset_dut();
      clear_results();
      prog.delete();
      prog.push_back(i_op(`CPU_OP_ADDI, 1, 0, 16'd9));
      prog.push_back(i_op(`CPU_OP_ADDI, 0, 1, 16'd5));
      prog.push_back(r_op(`CPU_FN_ADD, 0, 1, 1));
      prog.push_back(r_op(`CPU_FN_ADD, 2, 0, 1));
      prog.push_back(i_op(6'h3f, 1, 0, 16'h1234));
      prog.push_back(r_op(6'h00, 1, 2, 2));
      prog.push_back(r_op(6'h21, 1, 2, 2));
      prog.push_back(r_op(`CPU_FN_SUB, 3, 0, 1));
      prog.push_back(i_op(`CPU_OP_SW, 0, 0, 16'd0));
      prog.push_back(i_op(`CPU_OP_SW, 1, 0, 16'd4));
      prog.push_back(i_op(`CPU_OP_SW, 2, 0, 16'd8));
      prog.push_back(i_op(`CPU_OP_SW, 3, 0, 16'd12));
      run_program("r0 and nops", 1'b0);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("sim failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      run        = 1'b0;
      imem_addr  = '0;
      imem_wen   = 1'b0;
      imem_wdata = '0;
      dmem_addr  = '0;
      dmem_wen   = 1'b0;
      dmem_wdata = '0;
      reset_dut();
      test_external_access();
      test_alu_forwarding();
      test_load_use();
      test_freeze();
      test_zero_and_nops();
      $display("sim passed");
      $finish;
   end

endmodule

/* build.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/dual_port_ram.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/cpu.sv
sim/cpu_chk.sv
sim/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cpu_pkg.sv
      - verilog/dual_port_ram.sv
      - verilog/fetch_stage.sv
      - verilog/decode_stage.sv
      - verilog/execute_stage.sv
      - verilog/memory_stage.sv
      - verilog/cpu.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/cpu_chk.sv
      - sim/cpu_tb.sv
